// File: xaui_pkg.sv
package xaui_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus and datapath widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [15:0] wb_data_t;     // Wishbone data word
  typedef logic [1:0]  wb_sel_t;      // One select per byte lane
  typedef logic [63:0] xaui_word_t;   // FIFO and link word
  typedef logic [3:0]  fifo_status_t;
  typedef logic [63:0] count_t;
  typedef logic [7:0]  link_status_t;

  // Status bit positions inside fifo_status_t
  localparam int unsigned ST_EMPTY     = 0;
  localparam int unsigned ST_FULL      = 1;
  localparam int unsigned ST_OVERFLOW  = 2; // Sticky, push while full
  localparam int unsigned ST_UNDERFLOW = 3; // Sticky, pop while empty

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register index, taken from wb_adr_i[6:2]
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [4:0] {
    TXDATA3    = 5'd0,
    TXDATA2    = 5'd1,
    TXDATA1    = 5'd2,
    TXDATA0    = 5'd3,
    TXADVANCE  = 5'd4,
    TXSTATUS   = 5'd5,
    RXDATA3    = 5'd6,
    RXDATA2    = 5'd7,
    RXDATA1    = 5'd8,
    RXDATA0    = 5'd9,
    RXADVANCE  = 5'd10,
    RXSTATUS   = 5'd11,
    LINKSTATUS = 5'd12,
    POWERDOWN  = 5'd13,
    LOOPBACK   = 5'd14,
    TXEN       = 5'd15,
    RESET      = 5'd16,
    RXPHYCONF  = 5'd17,
    TXPHYCONF  = 5'd18,
    ERRCNT3    = 5'd19,
    ERRCNT2    = 5'd20,
    ERRCNT1    = 5'd21,
    ERRCNT0    = 5'd22,
    DATCNT3    = 5'd23,
    DATCNT2    = 5'd24,
    DATCNT1    = 5'd25,
    DATCNT0    = 5'd26
  } reg_idx_t; // 27 to 31 read as zero

endpackage

// File: xaui_fifo_if.sv
`timescale 1ns/1ps

interface xaui_fifo_if;

  logic                     push;
  xaui_pkg::xaui_word_t     push_data;
  logic                     pop;
  xaui_pkg::xaui_word_t     head_data;  // Oldest word, valid when not empty
  xaui_pkg::fifo_status_t   status;

  modport fifo (
    input  push,
    input  push_data,
    input  pop,
    output head_data,
    output status
  );

  modport user (
    output push,
    output push_data,
    output pop,
    input  head_data,
    input  status
  );

endinterface

// File: xaui_word_fifo.sv
`timescale 1ns/1ps

module xaui_word_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 2
) (
  input  logic         wb_clk_i,
  input  logic         reset,
  xaui_fifo_if.fifo    fifo
);

  localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

  typedef logic [FIFO_DEPTH_LOG2-1:0] ptr_t;
  typedef logic [FIFO_DEPTH_LOG2:0]   occ_t;

  localparam occ_t DEPTH_OCC = occ_t'(DEPTH);

  xaui_pkg::xaui_word_t mem [DEPTH];

  ptr_t rd_ptr;
  ptr_t wr_ptr;
  occ_t occupancy;
  logic empty;
  logic full;
  logic overflow_seen;
  logic underflow_seen;
  logic do_push;
  logic do_pop;

  assign empty   = (occupancy == '0);
  assign full    = (occupancy == DEPTH_OCC);
  assign do_pop  = fifo.pop & ~empty;
  assign do_push = fifo.push & (~full | do_pop); // Full FIFO takes a push if it pops too

  always_ff @(posedge wb_clk_i) begin
    if (reset) begin
      rd_ptr         <= '0;
      wr_ptr         <= '0;
      occupancy      <= '0;
      overflow_seen  <= 1'b0;
      underflow_seen <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
      if (fifo.push & ~do_push) overflow_seen  <= 1'b1;
      if (fifo.pop & empty)     underflow_seen <= 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (do_push) mem[wr_ptr] <= fifo.push_data;
  end

  assign fifo.head_data = mem[rd_ptr];

  always_comb begin
    fifo.status                         = '0;
    fifo.status[xaui_pkg::ST_EMPTY]     = empty;
    fifo.status[xaui_pkg::ST_FULL]      = full;
    fifo.status[xaui_pkg::ST_OVERFLOW]  = overflow_seen;
    fifo.status[xaui_pkg::ST_UNDERFLOW] = underflow_seen;
  end

  // Pointer and count bookkeeping must never run past the storage
  occupancy_bounded: assert property (
    @(posedge wb_clk_i) disable iff (reset) occupancy <= DEPTH_OCC
  );

endmodule

// File: xaui_wb_attach.sv
`timescale 1ns/1ps

module xaui_wb_attach #(
  parameter bit DEFAULT_POWERDOWN = 1'b0,
  parameter bit DEFAULT_LOOPBACK  = 1'b0,
  parameter bit DEFAULT_TXEN      = 1'b1
) (
  input  logic                   wb_clk_i,
  input  logic                   reset,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  xaui_pkg::wb_sel_t      wb_sel_i,
  input  logic [31:0]            wb_adr_i,
  input  xaui_pkg::wb_data_t     wb_dat_i,
  output xaui_pkg::wb_data_t     wb_dat_o,
  output logic                   wb_ack_o,
  input  xaui_pkg::link_status_t link_status_i,
  input  xaui_pkg::count_t       error_count_i,
  input  xaui_pkg::count_t       data_count_i,
  output logic                   powerdown_o,
  output logic                   loopback_o,
  output logic                   txen_o,
  output logic                   xaui_reset_strb_o,
  output logic [1:0]             rxeqmix_o,
  output logic [3:0]             rxeqpole_o,
  output logic [2:0]             txpreemphasis_o,
  output logic [2:0]             txdiffctrl_o,
  xaui_fifo_if.user              tx_fifo,
  xaui_fifo_if.user              rx_fifo
);

  xaui_pkg::reg_idx_t   wr_idx;
  xaui_pkg::reg_idx_t   rd_idx;   // Index of the cycle being acknowledged
  xaui_pkg::xaui_word_t tx_stage;
  logic                 accept;
  logic                 wr_en;
  logic                 strobe_bit;

  function automatic xaui_pkg::wb_data_t merge_lanes(
    input xaui_pkg::wb_data_t old_val,
    input xaui_pkg::wb_data_t new_val,
    input xaui_pkg::wb_sel_t  sel
  );
    xaui_pkg::wb_data_t result;
    result = old_val;
    if (sel[1]) result[15:8] = new_val[15:8];
    if (sel[0]) result[7:0]  = new_val[7:0];
    return result;
  endfunction

  assign accept     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_en      = accept & wb_we_i;
  assign strobe_bit = wb_sel_i[0] & wb_dat_i[0];
  assign wr_idx     = xaui_pkg::reg_idx_t'(wb_adr_i[6:2]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Ack, strobes and control registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge wb_clk_i) begin
    if (reset) begin
      wb_ack_o          <= 1'b0;
      xaui_reset_strb_o <= 1'b0;
      tx_fifo.push      <= 1'b0;
      rx_fifo.pop       <= 1'b0;
      powerdown_o       <= DEFAULT_POWERDOWN;
      loopback_o        <= DEFAULT_LOOPBACK;
      txen_o            <= DEFAULT_TXEN;
      rxeqmix_o         <= '0;
      rxeqpole_o        <= '0;
      txpreemphasis_o   <= '0;
      txdiffctrl_o      <= '0;
    end else begin
      wb_ack_o          <= accept;
      xaui_reset_strb_o <= wr_en & strobe_bit & (wr_idx == xaui_pkg::RESET);
      tx_fifo.push      <= wr_en & strobe_bit & (wr_idx == xaui_pkg::TXADVANCE);
      rx_fifo.pop       <= wr_en & strobe_bit & (wr_idx == xaui_pkg::RXADVANCE);
      if (wr_en & wb_sel_i[0]) begin
        case (wr_idx)
          xaui_pkg::POWERDOWN: powerdown_o     <= wb_dat_i[0];
          xaui_pkg::LOOPBACK:  loopback_o      <= wb_dat_i[0];
          xaui_pkg::TXEN:      txen_o          <= wb_dat_i[0];
          xaui_pkg::RXPHYCONF: rxeqmix_o       <= wb_dat_i[1:0];
          xaui_pkg::TXPHYCONF: txpreemphasis_o <= wb_dat_i[2:0];
          default: ;
        endcase
      end
      if (wr_en & wb_sel_i[1]) begin
        case (wr_idx)
          xaui_pkg::RXPHYCONF: rxeqpole_o   <= wb_dat_i[11:8];
          xaui_pkg::TXPHYCONF: txdiffctrl_o <= wb_dat_i[10:8];
          default: ;
        endcase
      end
    end
  end

  // Transmit staging word and the captured read index
  always_ff @(posedge wb_clk_i) begin
    if (accept) rd_idx <= wr_idx;
    if (wr_en) begin
      case (wr_idx)
        xaui_pkg::TXDATA3: tx_stage[63:48] <= merge_lanes(tx_stage[63:48], wb_dat_i, wb_sel_i);
        xaui_pkg::TXDATA2: tx_stage[47:32] <= merge_lanes(tx_stage[47:32], wb_dat_i, wb_sel_i);
        xaui_pkg::TXDATA1: tx_stage[31:16] <= merge_lanes(tx_stage[31:16], wb_dat_i, wb_sel_i);
        xaui_pkg::TXDATA0: tx_stage[15:0]  <= merge_lanes(tx_stage[15:0], wb_dat_i, wb_sel_i);
        default: ;
      endcase
    end
  end

  assign tx_fifo.push_data = tx_stage;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read mux, valid while ack is high
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    wb_dat_o = '0;
    case (rd_idx)
      xaui_pkg::TXDATA3:    wb_dat_o = tx_stage[63:48];
      xaui_pkg::TXDATA2:    wb_dat_o = tx_stage[47:32];
      xaui_pkg::TXDATA1:    wb_dat_o = tx_stage[31:16];
      xaui_pkg::TXDATA0:    wb_dat_o = tx_stage[15:0];
      xaui_pkg::TXSTATUS:   wb_dat_o = {12'b0, tx_fifo.status};
      xaui_pkg::RXDATA3:    wb_dat_o = rx_fifo.head_data[63:48];
      xaui_pkg::RXDATA2:    wb_dat_o = rx_fifo.head_data[47:32];
      xaui_pkg::RXDATA1:    wb_dat_o = rx_fifo.head_data[31:16];
      xaui_pkg::RXDATA0:    wb_dat_o = rx_fifo.head_data[15:0];
      xaui_pkg::RXSTATUS:   wb_dat_o = {12'b0, rx_fifo.status};
      xaui_pkg::LINKSTATUS: wb_dat_o = {8'b0, link_status_i};
      xaui_pkg::POWERDOWN:  wb_dat_o = {15'b0, powerdown_o};
      xaui_pkg::LOOPBACK:   wb_dat_o = {15'b0, loopback_o};
      xaui_pkg::TXEN:       wb_dat_o = {15'b0, txen_o};
      xaui_pkg::RXPHYCONF:  wb_dat_o = {4'b0, rxeqpole_o, 6'b0, rxeqmix_o};
      xaui_pkg::TXPHYCONF:  wb_dat_o = {5'b0, txdiffctrl_o, 5'b0, txpreemphasis_o};
      xaui_pkg::ERRCNT3:    wb_dat_o = error_count_i[63:48];
      xaui_pkg::ERRCNT2:    wb_dat_o = error_count_i[47:32];
      xaui_pkg::ERRCNT1:    wb_dat_o = error_count_i[31:16];
      xaui_pkg::ERRCNT0:    wb_dat_o = error_count_i[15:0];
      xaui_pkg::DATCNT3:    wb_dat_o = data_count_i[63:48];
      xaui_pkg::DATCNT2:    wb_dat_o = data_count_i[47:32];
      xaui_pkg::DATCNT1:    wb_dat_o = data_count_i[31:16];
      xaui_pkg::DATCNT0:    wb_dat_o = data_count_i[15:0];
      default:              wb_dat_o = '0; // Strobe registers and the unused range
    endcase
  end

  // Classic cycles are acknowledged at most every second clock
  ack_single_cycle: assert property (
    @(posedge wb_clk_i) disable iff (reset) wb_ack_o |=> !wb_ack_o
  );

endmodule

// File: xaui_lane_mux.sv
`timescale 1ns/1ps

module xaui_lane_mux (
  input  logic                 wb_clk_i,
  input  logic                 reset,
  input  logic                 powerdown_i,
  input  logic                 loopback_i,
  input  logic                 txen_i,
  input  logic                 reset_strb_i,
  input  logic                 link_rx_valid_i,
  input  xaui_pkg::xaui_word_t link_rx_data_i,
  output logic                 link_tx_valid_o,
  output xaui_pkg::xaui_word_t link_tx_data_o,
  output xaui_pkg::count_t     error_count_o,
  output xaui_pkg::count_t     data_count_o,
  xaui_fifo_if.user            tx_fifo,
  xaui_fifo_if.user            rx_fifo
);

  logic tx_ready;   // Transmit path enabled with a word waiting
  logic rx_full;
  logic loop_push;
  logic link_push;
  logic link_drop;
  logic send_link;

  assign rx_full  = rx_fifo.status[xaui_pkg::ST_FULL];
  assign tx_ready = txen_i & ~powerdown_i & ~tx_fifo.status[xaui_pkg::ST_EMPTY];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pop and push decisions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign loop_push = tx_ready & loopback_i & ~rx_full;
  assign send_link = tx_ready & ~loopback_i;
  assign link_push = link_rx_valid_i & ~loopback_i & ~powerdown_i & ~rx_full;
  assign link_drop = link_rx_valid_i & ~loopback_i & ~powerdown_i & rx_full;

  assign tx_fifo.pop       = loop_push | send_link; // Looped word waits while RX is full
  assign rx_fifo.push      = loop_push | link_push;
  assign rx_fifo.push_data = loopback_i ? tx_fifo.head_data : link_rx_data_i;

  always_ff @(posedge wb_clk_i) begin
    if (reset) begin
      link_tx_valid_o <= 1'b0;
      error_count_o   <= '0;
      data_count_o    <= '0;
    end else begin
      link_tx_valid_o <= send_link;
      if (reset_strb_i) begin // Link reset clears both counters
        error_count_o <= '0;
        data_count_o  <= '0;
      end else begin
        if (rx_fifo.push) data_count_o  <= data_count_o + 1'b1;
        if (link_drop)    error_count_o <= error_count_o + 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (send_link) link_tx_data_o <= tx_fifo.head_data;
  end

endmodule

// File: xaui_wb_top.sv
`timescale 1ns/1ps

module xaui_wb_top #(
  parameter bit DEFAULT_POWERDOWN = 1'b0,
  parameter bit DEFAULT_LOOPBACK  = 1'b0,
  parameter bit DEFAULT_TXEN      = 1'b1,
  parameter int FIFO_DEPTH_LOG2   = 2
) (
  input  logic                   wb_clk_i,
  input  logic                   reset,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  xaui_pkg::wb_sel_t      wb_sel_i,
  input  logic [31:0]            wb_adr_i,
  input  xaui_pkg::wb_data_t     wb_dat_i,
  output xaui_pkg::wb_data_t     wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   link_tx_valid_o,
  output xaui_pkg::xaui_word_t   link_tx_data_o,
  input  logic                   link_rx_valid_i,
  input  xaui_pkg::xaui_word_t   link_rx_data_i,
  input  xaui_pkg::link_status_t link_status_i,
  output logic                   powerdown_o,
  output logic                   loopback_o,
  output logic                   txen_o,
  output logic                   xaui_reset_strb_o,
  output logic [1:0]             rxeqmix_o,
  output logic [3:0]             rxeqpole_o,
  output logic [2:0]             txpreemphasis_o,
  output logic [2:0]             txdiffctrl_o
);

  xaui_pkg::count_t error_count;
  xaui_pkg::count_t data_count;

  xaui_fifo_if tx_fifo_if ();
  xaui_fifo_if rx_fifo_if ();

  xaui_word_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) i_tx_fifo (
    .wb_clk_i (wb_clk_i),
    .reset    (reset),
    .fifo     (tx_fifo_if.fifo)
  );

  xaui_word_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) i_rx_fifo (
    .wb_clk_i (wb_clk_i),
    .reset    (reset),
    .fifo     (rx_fifo_if.fifo)
  );

  xaui_wb_attach #(
    .DEFAULT_POWERDOWN (DEFAULT_POWERDOWN),
    .DEFAULT_LOOPBACK  (DEFAULT_LOOPBACK),
    .DEFAULT_TXEN      (DEFAULT_TXEN)
  ) i_wb_attach (
    .wb_clk_i          (wb_clk_i),
    .reset             (reset),
    .wb_cyc_i          (wb_cyc_i),
    .wb_stb_i          (wb_stb_i),
    .wb_we_i           (wb_we_i),
    .wb_sel_i          (wb_sel_i),
    .wb_adr_i          (wb_adr_i),
    .wb_dat_i          (wb_dat_i),
    .wb_dat_o          (wb_dat_o),
    .wb_ack_o          (wb_ack_o),
    .link_status_i     (link_status_i),
    .error_count_i     (error_count),
    .data_count_i      (data_count),
    .powerdown_o       (powerdown_o),
    .loopback_o        (loopback_o),
    .txen_o            (txen_o),
    .xaui_reset_strb_o (xaui_reset_strb_o),
    .rxeqmix_o         (rxeqmix_o),
    .rxeqpole_o        (rxeqpole_o),
    .txpreemphasis_o   (txpreemphasis_o),
    .txdiffctrl_o      (txdiffctrl_o),
    .tx_fifo           (tx_fifo_if.user),
    .rx_fifo           (rx_fifo_if.user)
  );

  xaui_lane_mux i_lane_mux (
    .wb_clk_i        (wb_clk_i),
    .reset           (reset),
    .powerdown_i     (powerdown_o),
    .loopback_i      (loopback_o),
    .txen_i          (txen_o),
    .reset_strb_i    (xaui_reset_strb_o),
    .link_rx_valid_i (link_rx_valid_i),
    .link_rx_data_i  (link_rx_data_i),
    .link_tx_valid_o (link_tx_valid_o),
    .link_tx_data_o  (link_tx_data_o),
    .error_count_o   (error_count),
    .data_count_o    (data_count),
    .tx_fifo         (tx_fifo_if.user),
    .rx_fifo         (rx_fifo_if.user)
  );

endmodule

// File: tb_xaui_checker.sv
`timescale 1ns/1ps

module tb_xaui_checker (
  input  logic                 wb_clk_i,
  input  logic                 reset,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  xaui_pkg::wb_sel_t    wb_sel_i,
  input  logic [31:0]          wb_adr_i,
  input  xaui_pkg::wb_data_t   wb_dat_i,
  input  xaui_pkg::wb_data_t   wb_dat_o,
  input  logic                 wb_ack_o,
  input  logic                 link_tx_valid_i,
  input  xaui_pkg::xaui_word_t link_tx_data_i,
  input  logic                 powerdown_i,
  input  logic                 loopback_i,
  input  logic                 txen_i,
  input  logic                 reset_strb_i,
  input  logic [1:0]           rxeqmix_i,
  input  logic [3:0]           rxeqpole_i,
  input  logic [2:0]           txpreemphasis_i,
  input  logic [2:0]           txdiffctrl_i,
  input  logic                 exp_rd_valid_i,
  input  xaui_pkg::wb_data_t   exp_rd_data_i,
  input  logic                 exp_tx_push_i,
  input  xaui_pkg::xaui_word_t exp_tx_word_i,
  input  logic [2:0]           exp_ctrl_i,   // {powerdown, loopback, txen}
  input  xaui_pkg::wb_data_t   exp_rxphy_i,
  input  xaui_pkg::wb_data_t   exp_txphy_i,
  output int                   tx_pending_o,
  output int                   read_errors_o,
  output int                   link_errors_o,
  output int                   ctrl_errors_o
);

  xaui_pkg::xaui_word_t exp_tx_q [$];
  xaui_pkg::xaui_word_t exp_word;
  xaui_pkg::wb_data_t   rxphy_now;
  xaui_pkg::wb_data_t   txphy_now;
  logic                 accepted;     // Cycle taken on this edge
  logic                 reset_acc;
  logic                 reset_acc_q;  // RESET write accepted on the previous edge
  logic                 ack_exp_q;
  logic                 rd_check_q;   // Expectation of the cycle now being acked
  xaui_pkg::wb_data_t   rd_exp_q;
  logic [4:0]           rd_idx_q;

  initial begin
    read_errors_o = 0;
    link_errors_o = 0;
    ctrl_errors_o = 0;
  end

  assign rxphy_now = {4'b0, rxeqpole_i, 6'b0, rxeqmix_i};
  assign txphy_now = {5'b0, txdiffctrl_i, 5'b0, txpreemphasis_i};
  assign accepted  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign reset_acc = accepted & wb_we_i & wb_sel_i[0] & wb_dat_i[0]
                     & (wb_adr_i[6:2] == xaui_pkg::RESET);
  assign tx_pending_o = exp_tx_q.size();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare on every rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge wb_clk_i) begin
    if (reset) begin
      reset_acc_q <= 1'b0;
      ack_exp_q   <= 1'b0;
      rd_check_q  <= 1'b0;
    end else begin
      if (exp_tx_push_i) exp_tx_q.push_back(exp_tx_word_i);
      if (wb_ack_o !== ack_exp_q) begin
        ctrl_errors_o++;
        $display("Error at %0t: wb_ack_o %b, expected %b", $time, wb_ack_o, ack_exp_q);
      end
      if (wb_ack_o && rd_check_q && wb_dat_o !== rd_exp_q) begin
        read_errors_o++;
        $display("Error at %0t: read index %0d gave %h, expected %h",
                 $time, rd_idx_q, wb_dat_o, rd_exp_q);
      end
      if (link_tx_valid_i) begin
        if (exp_tx_q.size() == 0) begin
          link_errors_o++;
          $display("Unexpected word %h on link_tx at %0t", link_tx_data_i, $time);
        end else begin
          exp_word = exp_tx_q.pop_front();
          if (link_tx_data_i !== exp_word) begin
            link_errors_o++;
            $display("Error at %0t: link_tx word %h, expected %h",
                     $time, link_tx_data_i, exp_word);
          end
        end
      end
      if ({powerdown_i, loopback_i, txen_i} !== exp_ctrl_i || rxphy_now !== exp_rxphy_i
          || txphy_now !== exp_txphy_i) begin
        ctrl_errors_o++;
        $display("Error at %0t: controls %b rx %h tx %h, expected %b rx %h tx %h", $time,
                 {powerdown_i, loopback_i, txen_i}, rxphy_now, txphy_now,
                 exp_ctrl_i, exp_rxphy_i, exp_txphy_i);
      end
      if (reset_strb_i !== reset_acc_q) begin
        ctrl_errors_o++;
        $display("Error at %0t: reset strobe %b, expected %b", $time, reset_strb_i, reset_acc_q);
      end
      reset_acc_q <= reset_acc;
      ack_exp_q   <= accepted;
      if (accepted) begin
        rd_check_q <= exp_rd_valid_i;
        rd_exp_q   <= exp_rd_data_i;
        rd_idx_q   <= wb_adr_i[6:2];
      end
    end
  end

endmodule

// File: tb_xaui.sv
`timescale 1ns/1ps

module tb_xaui;

  localparam bit DEF_PD     = 1'b0;
  localparam bit DEF_LB     = 1'b0;
  localparam bit DEF_TXEN   = 1'b1;
  localparam int DEPTH_LOG2 = 2;
  localparam int DEPTH      = 1 << DEPTH_LOG2;
  localparam int ACK_LIMIT  = 20;
  localparam int DRAIN_LIMIT = 200;

  logic                   wb_clk_i = 1'b0;
  logic                   reset;
  logic                   wb_cyc_i;
  logic                   wb_stb_i;
  logic                   wb_we_i;
  xaui_pkg::wb_sel_t      wb_sel_i;
  logic [31:0]            wb_adr_i;
  xaui_pkg::wb_data_t     wb_dat_i;
  xaui_pkg::wb_data_t     wb_dat_o;
  logic                   wb_ack_o;
  logic                   link_tx_valid_o;
  xaui_pkg::xaui_word_t   link_tx_data_o;
  logic                   link_rx_valid_i;
  xaui_pkg::xaui_word_t   link_rx_data_i;
  xaui_pkg::link_status_t link_status_i;
  logic                   powerdown_o;
  logic                   loopback_o;
  logic                   txen_o;
  logic                   xaui_reset_strb_o;
  logic [1:0]             rxeqmix_o;
  logic [3:0]             rxeqpole_o;
  logic [2:0]             txpreemphasis_o;
  logic [2:0]             txdiffctrl_o;

  logic                   exp_rd_valid;
  xaui_pkg::wb_data_t     exp_rd_data;
  logic                   exp_tx_push;
  xaui_pkg::xaui_word_t   exp_tx_word;
  int                     tx_pending;
  int                     read_errors;
  int                     link_errors;
  int                     ctrl_errors;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic                 m_pd;
  logic                 m_lb;
  logic                 m_txen;
  xaui_pkg::wb_data_t   m_rxphy;    // Readback view of RXPHYCONF
  xaui_pkg::wb_data_t   m_txphy;
  xaui_pkg::xaui_word_t m_stage;
  xaui_pkg::xaui_word_t tx_q [$];
  xaui_pkg::xaui_word_t rx_q [$];
  logic                 m_tx_ovf;
  logic                 m_rx_unf;
  xaui_pkg::count_t     m_err_cnt;
  xaui_pkg::count_t     m_dat_cnt;
  int                   rand_regs [9] = '{13, 14, 15, 17, 18, 0, 1, 2, 3};

  always #4 wb_clk_i = ~wb_clk_i;

  xaui_wb_top #(
    .DEFAULT_POWERDOWN (DEF_PD),
    .DEFAULT_LOOPBACK  (DEF_LB),
    .DEFAULT_TXEN      (DEF_TXEN),
    .FIFO_DEPTH_LOG2   (DEPTH_LOG2)
  ) i_dut (
    .wb_clk_i (wb_clk_i), .reset (reset), .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i),
    .wb_we_i (wb_we_i), .wb_sel_i (wb_sel_i), .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o), .link_tx_valid_o (link_tx_valid_o),
    .link_tx_data_o (link_tx_data_o), .link_rx_valid_i (link_rx_valid_i),
    .link_rx_data_i (link_rx_data_i), .link_status_i (link_status_i),
    .powerdown_o (powerdown_o), .loopback_o (loopback_o), .txen_o (txen_o),
    .xaui_reset_strb_o (xaui_reset_strb_o), .rxeqmix_o (rxeqmix_o), .rxeqpole_o (rxeqpole_o),
    .txpreemphasis_o (txpreemphasis_o), .txdiffctrl_o (txdiffctrl_o)
  );

  tb_xaui_checker i_checker (
    .wb_clk_i (wb_clk_i), .reset (reset), .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i),
    .wb_we_i (wb_we_i), .wb_sel_i (wb_sel_i), .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o), .link_tx_valid_i (link_tx_valid_o),
    .link_tx_data_i (link_tx_data_o), .powerdown_i (powerdown_o), .loopback_i (loopback_o),
    .txen_i (txen_o), .reset_strb_i (xaui_reset_strb_o), .rxeqmix_i (rxeqmix_o),
    .rxeqpole_i (rxeqpole_o), .txpreemphasis_i (txpreemphasis_o),
    .txdiffctrl_i (txdiffctrl_o), .exp_rd_valid_i (exp_rd_valid),
    .exp_rd_data_i (exp_rd_data), .exp_tx_push_i (exp_tx_push), .exp_tx_word_i (exp_tx_word),
    .exp_ctrl_i ({m_pd, m_lb, m_txen}), .exp_rxphy_i (m_rxphy), .exp_txphy_i (m_txphy),
    .tx_pending_o (tx_pending), .read_errors_o (read_errors), .link_errors_o (link_errors),
    .ctrl_errors_o (ctrl_errors)
  );

  function automatic xaui_pkg::wb_data_t model_read(input logic [4:0] idx);
    int k;
    xaui_pkg::xaui_word_t head;
    k = int'(idx);
    head = (rx_q.size() > 0) ? rx_q[0] : '0;
    if (k <= 3) return m_stage[16*(3-k) +: 16];
    if (k >= 6 && k <= 9) return head[16*(9-k) +: 16];
    if (k >= 19 && k <= 22) return m_err_cnt[16*(22-k) +: 16];
    if (k >= 23 && k <= 26) return m_dat_cnt[16*(26-k) +: 16];
    case (idx)
      xaui_pkg::TXSTATUS:   return {13'b0, m_tx_ovf, tx_q.size() == DEPTH, tx_q.size() == 0};
      xaui_pkg::RXSTATUS:   return {12'b0, m_rx_unf, 1'b0, rx_q.size() == DEPTH,
                                    rx_q.size() == 0};
      xaui_pkg::LINKSTATUS: return {8'b0, link_status_i};
      xaui_pkg::POWERDOWN:  return {15'b0, m_pd};
      xaui_pkg::LOOPBACK:   return {15'b0, m_lb};
      xaui_pkg::TXEN:       return {15'b0, m_txen};
      xaui_pkg::RXPHYCONF:  return m_rxphy;
      xaui_pkg::TXPHYCONF:  return m_txphy;
      default:              return '0;
    endcase
  endfunction

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic expect_tx(input xaui_pkg::xaui_word_t w);
    exp_tx_word = w;
    exp_tx_push = 1'b1;
    @(posedge wb_clk_i);
    #1;
    exp_tx_push = 1'b0;
  endtask

  task automatic model_write(input logic [4:0] idx, input xaui_pkg::wb_data_t d,
                             input xaui_pkg::wb_sel_t sel);
    int k;
    k = int'(idx);
    if (k <= 3) begin
      if (sel[1]) m_stage[16*(3-k)+8 +: 8] = d[15:8];
      if (sel[0]) m_stage[16*(3-k) +: 8]   = d[7:0];
    end
    if (sel[0]) begin
      case (idx)
        xaui_pkg::POWERDOWN: m_pd = d[0];
        xaui_pkg::LOOPBACK:  m_lb = d[0];
        xaui_pkg::TXEN:      m_txen = d[0];
        xaui_pkg::RXPHYCONF: m_rxphy[1:0] = d[1:0];
        xaui_pkg::TXPHYCONF: m_txphy[2:0] = d[2:0];
        xaui_pkg::TXADVANCE: if (d[0]) begin
          if (tx_q.size() == DEPTH) m_tx_ovf = 1'b1;
          else tx_q.push_back(m_stage);
        end
        xaui_pkg::RXADVANCE: if (d[0]) begin
          if (rx_q.size() == 0) m_rx_unf = 1'b1;
          else void'(rx_q.pop_front());
        end
        xaui_pkg::RESET: if (d[0]) begin
          m_err_cnt = '0;
          m_dat_cnt = '0;
        end
        default: ;
      endcase
    end
    if (sel[1] && idx == xaui_pkg::RXPHYCONF) m_rxphy[11:8] = d[11:8];
    if (sel[1] && idx == xaui_pkg::TXPHYCONF) m_txphy[10:8] = d[10:8];
    // Transmit FIFO drains whenever the path is enabled
    while (tx_q.size() > 0 && m_txen && !m_pd) begin
      if (m_lb) begin
        if (rx_q.size() == DEPTH) break;
        rx_q.push_back(tx_q.pop_front());
        m_dat_cnt = m_dat_cnt + 1;
      end else begin
        expect_tx(tx_q.pop_front());
      end
    end
  endtask

  task automatic wb_access(input logic we, input logic [4:0] idx, input xaui_pkg::wb_data_t d,
                           input xaui_pkg::wb_sel_t sel);
    int t;
    exp_rd_valid = ~we;
    exp_rd_data  = we ? '0 : model_read(idx);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {25'b0, idx, 2'b00};
    wb_dat_i = d;
    wb_sel_i = sel;
    t = 0;
    do begin
      @(posedge wb_clk_i);
      #1;
      t++;
    end while (!wb_ack_o && t < ACK_LIMIT);
    if (!wb_ack_o) report_timeout("wb_ack_o");
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (we) model_write(idx, d, sel);
  endtask

  task automatic wait_tx_drain();
    int t;
    t = 0;
    while (tx_pending > 0 && t < DRAIN_LIMIT) begin
      @(posedge wb_clk_i);
      #1;
      t++;
    end
    if (tx_pending > 0) report_timeout("transmit words on link_tx");
  endtask

  task automatic stage_and_advance();
    for (int i = 0; i < 4; i++) wb_access(1'b1, 5'(i), xaui_pkg::wb_data_t'($urandom), 2'b11);
    wb_access(1'b1, xaui_pkg::TXADVANCE, 16'h0001, 2'b11);
  endtask

  task automatic read_rx_word();
    for (int i = 6; i < 10; i++) wb_access(1'b0, 5'(i), '0, 2'b11);
    wb_access(1'b1, xaui_pkg::RXADVANCE, 16'h0001, 2'b11);
  endtask

  task automatic drive_link(input int n);
    for (int i = 0; i < n; i++) begin
      link_rx_valid_i = 1'b1;
      link_rx_data_i  = {$urandom, $urandom};
      if (rx_q.size() < DEPTH) begin
        rx_q.push_back(link_rx_data_i);
        m_dat_cnt = m_dat_cnt + 1;
      end else begin
        m_err_cnt = m_err_cnt + 1;   // Dropped while full
      end
      @(posedge wb_clk_i);
      #1;
    end
    link_rx_valid_i = 1'b0;
  endtask

  initial begin
    int n;
    void'($urandom(32'hba66_8beb));
    reset = 1'b1;
    {wb_cyc_i, wb_stb_i, wb_we_i, wb_sel_i, wb_adr_i, wb_dat_i} = '0;
    {link_rx_valid_i, link_rx_data_i, link_status_i} = '0;
    {exp_rd_valid, exp_rd_data, exp_tx_push, exp_tx_word} = '0;
    {m_pd, m_lb, m_txen} = {DEF_PD, DEF_LB, DEF_TXEN};
    {m_rxphy, m_txphy, m_stage, m_tx_ovf, m_rx_unf, m_err_cnt, m_dat_cnt} = '0;
    repeat (16) @(posedge wb_clk_i);
    #1;
    reset = 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset values, then random register traffic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (int i = 4; i < 32; i++) if (i < 6 || i > 9) wb_access(1'b0, 5'(i), '0, 2'b11);
    for (int i = 0; i < 4; i++) wb_access(1'b1, 5'(i), 16'h0000, 2'b11);
    for (int i = 0; i < 40; i++) begin
      n = rand_regs[$urandom_range(0, 8)];
      wb_access(1'b1, 5'(n), xaui_pkg::wb_data_t'($urandom), xaui_pkg::wb_sel_t'($urandom));
      wb_access(1'b0, 5'(n), '0, 2'b11);
    end
    wb_access(1'b1, xaui_pkg::POWERDOWN, 16'h0000, 2'b11);
    wb_access(1'b1, xaui_pkg::LOOPBACK, 16'h0000, 2'b11);
    wb_access(1'b1, xaui_pkg::TXEN, 16'h0001, 2'b11);

    // Link transmit, then overflow while powered down
    n = $urandom_range(3, 6);
    for (int i = 0; i < n; i++) stage_and_advance();
    wait_tx_drain();
    wb_access(1'b1, xaui_pkg::POWERDOWN, 16'h0001, 2'b01);
    for (int i = 0; i <= DEPTH; i++) stage_and_advance();
    wb_access(1'b0, xaui_pkg::TXSTATUS, '0, 2'b11);
    wb_access(1'b1, xaui_pkg::POWERDOWN, 16'h0000, 2'b01);
    wait_tx_drain();
    wb_access(1'b0, xaui_pkg::TXSTATUS, '0, 2'b11);

    // Loopback into the receive FIFO
    wb_access(1'b1, xaui_pkg::LOOPBACK, 16'h0001, 2'b01);
    n = $urandom_range(1, DEPTH);
    for (int i = 0; i < n; i++) stage_and_advance();
    repeat (4) @(posedge wb_clk_i);
    #1;
    wb_access(1'b0, xaui_pkg::DATCNT0, '0, 2'b11);
    for (int i = 0; i < n; i++) read_rx_word();
    wb_access(1'b1, xaui_pkg::RXADVANCE, 16'h0001, 2'b11);
    wb_access(1'b0, xaui_pkg::RXSTATUS, '0, 2'b11);

    // Link receive with drops
    wb_access(1'b1, xaui_pkg::LOOPBACK, 16'h0000, 2'b01);
    link_status_i = xaui_pkg::link_status_t'($urandom);
    wb_access(1'b0, xaui_pkg::LINKSTATUS, '0, 2'b11);
    drive_link(DEPTH + $urandom_range(1, 4));
    wb_access(1'b0, xaui_pkg::RXSTATUS, '0, 2'b11);
    for (int i = 19; i < 27; i++) wb_access(1'b0, 5'(i), '0, 2'b11);
    for (int i = 0; i < DEPTH; i++) read_rx_word();

    // Link reset clears the counters
    wb_access(1'b1, xaui_pkg::RESET, 16'h0001, 2'b11);
    wb_access(1'b0, xaui_pkg::ERRCNT0, '0, 2'b11);
    wb_access(1'b0, xaui_pkg::DATCNT0, '0, 2'b11);
    repeat (4) @(posedge wb_clk_i);

    $display("Errors: read %0d, link %0d, control %0d, missing link words %0d",
             read_errors, link_errors, ctrl_errors, tx_pending);
    if (read_errors + link_errors + ctrl_errors + tx_pending == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb.f
xaui_pkg.sv
xaui_fifo_if.sv
xaui_word_fifo.sv
xaui_wb_attach.sv
xaui_lane_mux.sv
xaui_wb_top.sv
tb_xaui_checker.sv
tb_xaui.sv

// File: Makefile
TOP = tb_xaui

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
